//--- hw/rv_isa_pkg.sv
// RV32I encodings and the control types shared by the core's data path and control unit
// import with rv_isa_pkg::* in the module header where needed
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLL    = 5'd2,
    ALU_SLT    = 5'd3,
    ALU_SLTU   = 5'd4,
    ALU_XOR    = 5'd5,
    ALU_SRL    = 5'd6,
    ALU_SRA    = 5'd7,
    ALU_OR     = 5'd8,
    ALU_AND    = 5'd9,
    ALU_SEQ    = 5'd10, // 1 when operands are equal
    ALU_PASS_B = 5'd11
  } alu_function_t;

  typedef enum logic [1:0] {
    NEXT_PC_PLUS_4   = 2'd0,
    NEXT_PC_PLUS_IMM = 2'd1,
    NEXT_PC_ALU      = 2'd2, // jalr target with bit 0 cleared
    NEXT_PC_HOLD     = 2'd3
  } next_pc_sel_t;

  typedef enum logic [2:0] {
    WB_ALU       = 3'd0,
    WB_MEM       = 3'd1,
    WB_PC_PLUS_4 = 3'd2,
    WB_IMM       = 3'd3
  } writeback_sel_t;

  localparam logic OP_A_RS1 = 1'b0;
  localparam logic OP_A_PC  = 1'b1;
  localparam logic OP_B_RS2 = 1'b0;
  localparam logic OP_B_IMM = 1'b1;

  typedef struct packed {
    logic           pc_write_enable;
    logic           regfile_write_enable;
    logic           alu_operand_a_select;
    logic           alu_operand_b_select;
    writeback_sel_t reg_writeback_select;
    next_pc_sel_t   next_pc_select;
    alu_function_t  alu_function;
  } ctrl_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] immediate;
  } inst_fields_t;

endpackage

//--- hw/rv_bus_pkg.sv
// APB request and response bundles for the core's data memory port
// import with rv_bus_pkg::* in the module header where needed
package rv_bus_pkg;

  localparam int APB_ADDR_WIDTH = 32;
  localparam int APB_DATA_WIDTH = 32;

  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
  } apb_rsp_t;

endpackage

//--- hw/instruction_decoder.sv
// Splits an RV32I instruction word into its fields
// and builds the sign-extended immediate for the instruction's format
`timescale 1ns/1ps

module instruction_decoder import rv_isa_pkg::*; (
  input  logic [31:0]  inst,
  output inst_fields_t fields
);

  opcode_t opcode;

  assign opcode = opcode_t'(inst[6:0]);

  always_comb begin
    fields.opcode = opcode;
    fields.funct3 = inst[14:12];
    fields.funct7 = inst[31:25];
    fields.rd     = inst[11:7];
    fields.rs1    = inst[19:15];
    fields.rs2    = inst[24:20];

    case (opcode)
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:
        fields.immediate = {{20{inst[31]}}, inst[31:20]};
      OPC_STORE:
        fields.immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      OPC_BRANCH:
        fields.immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC:
        fields.immediate = {inst[31:12], 12'b0};
      OPC_JAL:
        fields.immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        fields.immediate = 32'b0; // OP has no immediate
    endcase
  end

endmodule

//--- hw/regfile.sv
// 32 x 32 integer register file with x0 hard-wired to zero
// two combinational read ports, one write port on the rising edge
`timescale 1ns/1ps

module regfile (
  input  logic        clock,
  input  logic        write_enable,
  input  logic [4:0]  rd_address,
  input  logic [4:0]  rs1_address,
  input  logic [4:0]  rs2_address,
  input  logic [31:0] rd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != 5'd0)
      regs[rd_address] <= rd_data;
  end

  // entry 0 is never written, so it is masked on read
  assign rs1_data = (rs1_address == 5'd0) ? 32'b0 : regs[rs1_address];
  assign rs2_data = (rs2_address == 5'd0) ? 32'b0 : regs[rs2_address];

endmodule

//--- hw/alu.sv
// RV32I arithmetic, logic, shift and compare unit
// the zero flag is what the control unit uses to resolve branches
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
  input  alu_function_t alu_function,
  input  logic [31:0]   operand_a,
  input  logic [31:0]   operand_b,
  output logic [31:0]   result,
  output logic          result_equal_zero
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      ALU_ADD:    result = operand_a + operand_b;
      ALU_SUB:    result = operand_a - operand_b;
      ALU_SLL:    result = operand_a << shamt;
      ALU_SLT:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      ALU_SLTU:   result = {31'b0, operand_a < operand_b};
      ALU_XOR:    result = operand_a ^ operand_b;
      ALU_SRL:    result = operand_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(operand_a) >>> shamt);
      ALU_OR:     result = operand_a | operand_b;
      ALU_AND:    result = operand_a & operand_b;
      ALU_SEQ:    result = {31'b0, operand_a == operand_b};
      ALU_PASS_B: result = operand_b;
      default:    result = 32'b0;
    endcase
  end

  assign result_equal_zero = (result == 32'b0);

endmodule

//--- hw/singlecycle_datapath.sv
// Single-cycle RV32I data path: PC register, register file, ALU and the selects around them
// all selects and write enables come from the control unit through ctrl
`timescale 1ns/1ps

module singlecycle_datapath import rv_isa_pkg::*; #(
  parameter logic [31:0] INITIAL_PC = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        rst,
  input  logic [31:0] inst,
  input  ctrl_t       ctrl,
  input  logic [31:0] mem_read_data,
  output logic [31:0] pc,
  output logic [31:0] data_mem_address,
  output logic [31:0] data_mem_write_data,
  output opcode_t     opcode,
  output logic [2:0]  funct3,
  output logic [6:0]  funct7,
  output logic        alu_result_equal_zero
);

  inst_fields_t fields;
  logic [31:0]  rs1_data;
  logic [31:0]  rs2_data;
  logic [31:0]  operand_a;
  logic [31:0]  operand_b;
  logic [31:0]  alu_result;
  logic [31:0]  pc_plus_4;
  logic [31:0]  pc_plus_imm;
  logic [31:0]  next_pc;
  logic [31:0]  writeback_data;

  instruction_decoder i_instruction_decoder (
    .inst   (inst),
    .fields (fields)
  );

  regfile i_regfile (
    .clock        (clock),
    .write_enable (ctrl.regfile_write_enable),
    .rd_address   (fields.rd),
    .rs1_address  (fields.rs1),
    .rs2_address  (fields.rs2),
    .rd_data      (writeback_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = (ctrl.alu_operand_a_select == OP_A_PC) ? pc : rs1_data;
  assign operand_b = (ctrl.alu_operand_b_select == OP_B_IMM) ? fields.immediate : rs2_data;

  alu i_alu (
    .alu_function      (ctrl.alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (alu_result_equal_zero)
  );

  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + fields.immediate; // branch and jal target

  always_comb begin
    case (ctrl.next_pc_select)
      NEXT_PC_PLUS_4:   next_pc = pc_plus_4;
      NEXT_PC_PLUS_IMM: next_pc = pc_plus_imm;
      NEXT_PC_ALU:      next_pc = {alu_result[31:1], 1'b0};
      default:          next_pc = pc;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst)
      pc <= INITIAL_PC;
    else if (ctrl.pc_write_enable)
      pc <= next_pc;
  end

  always_comb begin
    case (ctrl.reg_writeback_select)
      WB_MEM:       writeback_data = mem_read_data;
      WB_PC_PLUS_4: writeback_data = pc_plus_4; // link address of jal and jalr
      WB_IMM:       writeback_data = fields.immediate;
      default:      writeback_data = alu_result;
    endcase
  end

  // loads and stores compute rs1 + offset in the ALU
  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

  assign opcode = fields.opcode;
  assign funct3 = fields.funct3;
  assign funct7 = fields.funct7;

endmodule

//--- hw/control_unit.sv
// Combinational control for the single-cycle core
// loads and stores hold the PC until the APB data port reports mem_done
`timescale 1ns/1ps

module control_unit import rv_isa_pkg::*; (
  input  opcode_t    opcode,
  input  logic [2:0] funct3,
  input  logic [6:0] funct7,
  input  logic       alu_result_equal_zero,
  input  logic       mem_done,
  output ctrl_t      ctrl,
  output logic       mem_start,
  output logic       mem_write
);

  // alt selects sub for add and sra for srl
  function automatic alu_function_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  logic branch_taken;

  // beq, blt and bltu take the branch on a 1 result, the odd funct3 forms on a 0 result
  assign branch_taken = (alu_result_equal_zero == funct3[0]);

  always_comb begin
    ctrl                      = '0;
    ctrl.pc_write_enable      = 1'b1;
    ctrl.alu_operand_a_select = OP_A_RS1;
    ctrl.alu_operand_b_select = OP_B_IMM;
    ctrl.reg_writeback_select = WB_ALU;
    ctrl.next_pc_select       = NEXT_PC_PLUS_4;
    ctrl.alu_function         = ALU_ADD;
    mem_start                 = 1'b0;
    mem_write                 = 1'b0;

    case (opcode)
      OPC_LUI: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.alu_function         = ALU_PASS_B;
        ctrl.reg_writeback_select = WB_IMM;
      end
      OPC_AUIPC: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.alu_operand_a_select = OP_A_PC;
      end
      OPC_JAL: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.reg_writeback_select = WB_PC_PLUS_4;
        ctrl.next_pc_select       = NEXT_PC_PLUS_IMM;
      end
      OPC_JALR: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.reg_writeback_select = WB_PC_PLUS_4;
        ctrl.next_pc_select       = NEXT_PC_ALU;
      end
      OPC_BRANCH: begin
        ctrl.alu_operand_b_select = OP_B_RS2;
        case (funct3[2:1])
          2'b10:   ctrl.alu_function = ALU_SLT;
          2'b11:   ctrl.alu_function = ALU_SLTU;
          default: ctrl.alu_function = ALU_SEQ;
        endcase
        ctrl.next_pc_select = branch_taken ? NEXT_PC_PLUS_IMM : NEXT_PC_PLUS_4;
      end
      OPC_OP_IMM: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.alu_function = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
      end
      OPC_OP: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.alu_operand_b_select = OP_B_RS2;
        ctrl.alu_function         = alu_from_funct3(funct3, funct7[5]);
      end
      OPC_LOAD: begin
        ctrl.pc_write_enable      = mem_done;
        ctrl.regfile_write_enable = mem_done; // load data arrives with pready
        ctrl.reg_writeback_select = WB_MEM;
        mem_start                 = !mem_done;
      end
      OPC_STORE: begin
        ctrl.pc_write_enable = mem_done;
        mem_start            = !mem_done;
        mem_write            = 1'b1;
      end
      default: begin
        ctrl.pc_write_enable = 1'b0; // the core stops at an unknown opcode
        ctrl.next_pc_select  = NEXT_PC_HOLD;
      end
    endcase
  end

endmodule

//--- hw/apb_data_port.sv
// APB requester for the core's data memory, one transfer per load or store
// mem_done pulses in the access cycle that sees pready
`timescale 1ns/1ps

module apb_data_port import rv_bus_pkg::*; (
  input  logic        clock,
  input  logic        rst,
  input  logic        mem_start,
  input  logic        mem_write,
  input  logic [31:0] address,
  input  logic [31:0] write_data,
  input  apb_rsp_t    apb_rsp,
  output apb_req_t    apb_req,
  output logic        mem_done,
  output logic [31:0] mem_read_data
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

  state_t      state;
  logic [31:0] address_q;
  logic [31:0] write_data_q;
  logic        write_q;

  always_ff @(posedge clock) begin
    if (rst) begin
      state   <= IDLE;
      write_q <= 1'b0;
    end else begin
      case (state)
        IDLE: if (mem_start) begin
          state   <= SETUP;
          write_q <= mem_write;
        end
        SETUP:   state <= ACCESS;
        default: if (apb_rsp.pready) state <= IDLE;
      endcase
    end
  end

  // request payload is captured once and held until the transfer ends
  always_ff @(posedge clock) begin
    if (state == IDLE && mem_start) begin
      address_q    <= address;
      write_data_q <= write_data;
    end
  end

  assign apb_req.paddr   = address_q;
  assign apb_req.pwdata  = write_data_q;
  assign apb_req.pwrite  = write_q;
  assign apb_req.psel    = (state != IDLE);
  assign apb_req.penable = (state == ACCESS);

  assign mem_done      = (state == ACCESS) && apb_rsp.pready;
  assign mem_read_data = apb_rsp.prdata;

endmodule

//--- hw/rv_core.sv
// Top level of the single-cycle RV32I core
// instruction fetch is combinational on pc/inst, data memory goes over APB
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, rv_bus_pkg::*; #(
  parameter logic [31:0] INITIAL_PC = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        rst,
  output logic [31:0] pc,
  input  logic [31:0] inst,
  output apb_req_t    apb_req,
  input  apb_rsp_t    apb_rsp
);

  ctrl_t       ctrl;
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        alu_result_equal_zero;
  logic [31:0] data_mem_address;
  logic [31:0] data_mem_write_data;
  logic [31:0] mem_read_data;
  logic        mem_start;
  logic        mem_write;
  logic        mem_done;

  singlecycle_datapath #(.INITIAL_PC(INITIAL_PC)) i_singlecycle_datapath (
    .clock                 (clock),
    .rst                   (rst),
    .inst                  (inst),
    .ctrl                  (ctrl),
    .mem_read_data         (mem_read_data),
    .pc                    (pc),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .opcode                (opcode),
    .funct3                (funct3),
    .funct7                (funct7),
    .alu_result_equal_zero (alu_result_equal_zero)
  );

  control_unit i_control_unit (
    .opcode                (opcode),
    .funct3                (funct3),
    .funct7                (funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .mem_done              (mem_done),
    .ctrl                  (ctrl),
    .mem_start             (mem_start),
    .mem_write             (mem_write)
  );

  apb_data_port i_apb_data_port (
    .clock         (clock),
    .rst           (rst),
    .mem_start     (mem_start),
    .mem_write     (mem_write),
    .address       (data_mem_address),
    .write_data    (data_mem_write_data),
    .apb_rsp       (apb_rsp),
    .apb_req       (apb_req),
    .mem_done      (mem_done),
    .mem_read_data (mem_read_data)
  );

endmodule

//--- test/rv_core_properties.sv
// APB requester and PC alignment assertions for rv_core
// attached to every rv_core instance by the bind at the end of this file
`timescale 1ns/1ps

module rv_core_properties import rv_bus_pkg::*; (
  input logic        clock,
  input logic        rst,
  input logic [31:0] pc,
  input apb_req_t    apb_req,
  input apb_rsp_t    apb_rsp
);

  penable_needs_psel: assert property (@(posedge clock) disable iff (rst)
    apb_req.penable |-> apb_req.psel)
    else $error("penable high while psel is low");

  // from setup until the access cycle with pready the payload must not move
  payload_stable: assert property (@(posedge clock) disable iff (rst)
    (apb_req.psel && !(apb_req.penable && apb_rsp.pready)) |=>
      ($stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata)))
    else $error("APB request changed while waiting for pready");

  pc_aligned: assert property (@(posedge clock) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  idle_after_reset: assert property (@(posedge clock)
    rst |=> (!apb_req.psel && !apb_req.penable))
    else $error("APB request active in the cycle after reset");

endmodule

bind rv_core rv_core_properties i_rv_core_properties (
  .clock   (clock),
  .rst     (rst),
  .pc      (pc),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp)
);

//--- test/rv_core_tb.sv
// Testbench for rv_core that runs a program and its expected stores from the tests data file
// an APB memory completer with random wait states checks every store against the list
`timescale 1ns/1ps

module rv_core_tb import rv_bus_pkg::*; ();

  localparam logic [31:0] JAL_SELF = 32'h0000_006f; // jal x0, 0 ends each program

  logic        clock = 1'b0;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] inst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  logic [31:0] tests [256];
  logic [31:0] data_mem [64];
  logic [31:0] prog_len;
  logic [31:0] store_total;
  logic [7:0]  store_count;
  logic [31:0] cycle_count;
  logic [31:0] cycle_limit;
  logic [1:0]  wait_left;
  logic [31:0] lfsr_state;

  always #20 clock = ~clock;

  rv_core #(.INITIAL_PC(32'h0000_0000)) i_rv_core (
    .clock   (clock),
    .rst     (rst),
    .pc      (pc),
    .inst    (inst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  // program words start at entry 2, anything past the end reads as jump-to-self
  assign inst = ({2'b0, pc[31:2]} < prog_len) ? tests[pc[9:2] + 8'd2] : JAL_SELF;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected)
      fail_run($sformatf("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                         $time, name, actual, expected));
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    logic [7:0] idx;
    if ({24'b0, store_count} >= store_total)
      fail_run("unexpected APB write after the last expected store");
    idx = 8'(32'd2 + prog_len + {23'b0, store_count, 1'b0}); // address, data pairs
    check("paddr", addr, tests[idx]);
    check("pwdata", data, tests[idx + 8'd1]);
    store_count = store_count + 8'd1;
  endtask

  // the completer always waits in the first access cycle and then adds 0 to 3 more
  always @(posedge clock) begin : apb_completer
    logic [1:0] bits;
    if (rst) begin
      apb_rsp.pready <= 1'b0;
      wait_left      <= 2'd0;
    end else begin
      apb_rsp.pready <= 1'b0;
      if (apb_req.psel && !apb_req.penable) begin
        bits[0]    = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        bits[1]    = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        wait_left <= bits;
      end else if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
        if (wait_left != 2'd0) begin
          wait_left <= wait_left - 2'd1;
        end else begin
          apb_rsp.pready <= 1'b1;
          apb_rsp.prdata <= data_mem[apb_req.paddr[7:2]];
          if (apb_req.pwrite) begin
            data_mem[apb_req.paddr[7:2]] = apb_req.pwdata;
            check_store(apb_req.paddr, apb_req.pwdata);
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [6:0] i;
    rst         <= 1'b1;
    apb_rsp     <= '0;
    wait_left   <= 2'd0;
    lfsr_state  = 32'h585d_f6ff;
    store_count = 8'd0;
    cycle_count = 32'd0;
    $readmemh("test/rv_core_tests.mem", tests);
    prog_len    = tests[0];
    store_total = tests[1];
    cycle_limit = 32'd64 * (prog_len + store_total);
    for (i = 7'd0; i < 7'd64; i++)
      data_mem[i[5:0]] = {16'hDA7A, 10'h0, i[5:0]};

    repeat (2) begin
      @(negedge clock);
      check("pc", pc, 32'h0000_0000);
      check("psel", {31'b0, apb_req.psel}, 32'd0);
    end
    @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    check("pc", pc, 32'h0000_0000); // still INITIAL_PC in the first cycle out of reset
    check("psel", {31'b0, apb_req.psel}, 32'd0);

    while (!(inst == JAL_SELF && !apb_req.psel)) begin
      @(negedge clock);
      cycle_count = cycle_count + 32'd1;
      if (cycle_count > cycle_limit)
        fail_run("timeout: the program did not reach its final jump-to-self");
    end
    check("store_count", {24'b0, store_count}, store_total);
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- test/rv_core_tests.mem
// word 0 program length, word 1 store count, then program words from pc 0
// then one expected store per line: address, data
0000002a 0000000b
123450b7 67808093 00102023 ffb00113
40115193 40208233 001122b3 00113333
00302223 00402423 00502623 00602823
00001397 00702a23 00628463 00100413
00114463 00240413 00116463 00440413
00629463 00840413 00115463 01040413
00117463 02040413 00802c23 008004ef
02002e23 00c48567 02002e23 00902e23
02a02023 00002583 00802603 00c5c6b3
00469693 02d02223 02402703 00c707b3
02f02423 0000006f
00000000 12345678
00000004 fffffffd
00000008 1234567d
0000000c 00000001
00000010 00000000
00000014 00001030
00000018 00000015
0000001c 00000070
00000020 00000078
00000024 00000050
00000028 123456cd

//--- project.f
hw/rv_isa_pkg.sv
hw/rv_bus_pkg.sv
hw/instruction_decoder.sv
hw/regfile.sv
hw/alu.sv
hw/singlecycle_datapath.sv
hw/control_unit.sv
hw/apb_data_port.sv
hw/rv_core.sv
test/rv_core_properties.sv
test/rv_core_tb.sv

//--- Makefile
# Verilator build and run of the rv_core testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module rv_core_tb -o rv_core_sim
	./obj_dir/rv_core_sim | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
